/* rtl/vid_bridge_macros.svh */
`ifndef VID_BRIDGE_MACROS_SVH
`define VID_BRIDGE_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// Raster timing per format, active / front porch / sync / back porch
////////////////////////////////////////////////////////////////////////

// 640x480@60
`define VB_VGA_HPIXELS   11'd640
`define VB_VGA_HFNPRCH   11'd16
`define VB_VGA_HSYNCPW   11'd96
`define VB_VGA_HBKPRCH   11'd48
`define VB_VGA_VLINES    11'd480
`define VB_VGA_VFNPRCH   11'd11
`define VB_VGA_VSYNCPW   11'd2
`define VB_VGA_VBKPRCH   11'd31

// 800x600@60
`define VB_SVGA_HPIXELS  11'd800
`define VB_SVGA_HFNPRCH  11'd40
`define VB_SVGA_HSYNCPW  11'd128
`define VB_SVGA_HBKPRCH  11'd88
`define VB_SVGA_VLINES   11'd600
`define VB_SVGA_VFNPRCH  11'd1
`define VB_SVGA_VSYNCPW  11'd4
`define VB_SVGA_VBKPRCH  11'd23

// 1024x768@60
`define VB_XGA_HPIXELS   11'd1024
`define VB_XGA_HFNPRCH   11'd24
`define VB_XGA_HSYNCPW   11'd136
`define VB_XGA_HBKPRCH   11'd160
`define VB_XGA_VLINES    11'd768
`define VB_XGA_VFNPRCH   11'd3
`define VB_XGA_VSYNCPW   11'd6
`define VB_XGA_VBKPRCH   11'd29

// 1280x720@60, also the fallback format
`define VB_720P_HPIXELS  11'd1280
`define VB_720P_HFNPRCH  11'd110
`define VB_720P_HSYNCPW  11'd40
`define VB_720P_HBKPRCH  11'd220
`define VB_720P_VLINES   11'd720
`define VB_720P_VFNPRCH  11'd5
`define VB_720P_VSYNCPW  11'd5
`define VB_720P_VBKPRCH  11'd20

// Sync polarity, 1 = active low
`define VB_VGA_NEG       1'b1
`define VB_SVGA_NEG      1'b0
`define VB_XGA_NEG       1'b1
`define VB_720P_NEG      1'b0

`define VB_FIFO_DEPTH    16         // Pixel words, also initial credits
`define VB_FILL_PIXEL    24'h000000 // Black on underrun and blanking

`endif

/* rtl/vid_bridge_pkg.sv */
package vid_bridge_pkg;

	////////////////////////////////////////////////////////////////////
	// Shared types
	////////////////////////////////////////////////////////////////////

	// Raster counter or timing boundary
	typedef logic [10:0] coord_t;

	// Packed RGB pixel
	typedef logic [23:0] pixel_t; // [23:16] red, [15:8] green, [7:0] blue

	// Format code, same as the board switch encoding
	typedef enum logic [3:0] {
		MODE_VGA  = 4'b0000,
		MODE_SVGA = 4'b0001,
		MODE_720P = 4'b0010, // Any unlisted code falls back here
		MODE_XGA  = 4'b0011
	} vid_mode_e;

endpackage

/* rtl/raster_if.sv */
`timescale 1ns/1ps

// Raster state from timing generator to output stage
interface raster_if;

	vid_bridge_pkg::coord_t hcount; // Pixel within line
	vid_bridge_pkg::coord_t vcount; // Line within frame
	logic hblnk;     // Horizontal blanking
	logic vblnk;     // Vertical blanking
	logic hsync_raw; // Active high, before polarity fix
	logic vsync_raw;
	logic sync_neg;  // Latched format wants active low syncs

	modport gen (
		output hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw, sync_neg
	);

	modport sink (
		input hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw, sync_neg
	);

endinterface

/* rtl/pixel_rx_buffer.sv */
`timescale 1ns/1ps

`include "vid_bridge_macros.svh"

module pixel_rx_buffer (
	input  logic                   clk50m_bufg,
	input  logic                   serdes_rst,
	input  logic                   px_valid,      // One beat spends one credit
	input  vid_bridge_pkg::pixel_t px_data,
	input  logic                   pop,           // Consume head this cycle
	output vid_bridge_pkg::pixel_t head,          // Valid while avail
	output logic                   avail,
	output logic                   credit_return  // One pulse per pop
);

localparam int AW = $clog2(`VB_FIFO_DEPTH);

vid_bridge_pkg::pixel_t mem [`VB_FIFO_DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0]   count; // Occupancy, 0..DEPTH
logic          full;
logic          wr_en;
logic          rd_en;

assign full  = (count == (AW+1)'(`VB_FIFO_DEPTH));
assign avail = (count != '0);
assign wr_en = px_valid && !full; // Overflow beat dropped, assertion flags it
assign rd_en = pop && avail;
assign head  = mem[rd_ptr];       // Fall-through, no read latency

// Storage, no reset
always_ff @(posedge clk50m_bufg) begin
	if (wr_en)
		mem[wr_ptr] <= px_data;
end

// Pointers, occupancy and credit pulse
always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
	if (serdes_rst) begin
		wr_ptr        <= '0;
		rd_ptr        <= '0;
		count         <= '0;
		credit_return <= 1'b0;
	end else begin
		if (wr_en)
			wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, wraps free
		if (rd_en)
			rd_ptr <= rd_ptr + 1'b1;
		case ({wr_en, rd_en})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;     // Both or neither
		endcase
		credit_return <= rd_en; // Slot freed, hand credit back next cycle
	end
end

////////////////////////////////////////////////////////////////////////
// Flow control checks
////////////////////////////////////////////////////////////////////////

// Producer must hold a credit, so never a beat into a full buffer
a_no_overflow: assert property (
	@(posedge clk50m_bufg) disable iff (serdes_rst)
	px_valid |-> !full
) else $error("pixel_rx_buffer: write while full, credit rule broken");

// Output stage only pops what is there
a_no_empty_pop: assert property (
	@(posedge clk50m_bufg) disable iff (serdes_rst)
	pop |-> avail
) else $error("pixel_rx_buffer: pop while empty");

endmodule

/* rtl/raster_timing_gen.sv */
`timescale 1ns/1ps

`include "vid_bridge_macros.svh"

module raster_timing_gen (
	input  logic                      clk50m_bufg,
	input  logic                      serdes_rst,
	input  vid_bridge_pkg::vid_mode_e mode,    // Sampled at frame wrap only
	raster_if.gen                     rst_bus
);

vid_bridge_pkg::vid_mode_e mode_q; // Format of the running frame

// Per-format boundaries
vid_bridge_pkg::coord_t h_act, h_fp, h_sw, h_bp;
vid_bridge_pkg::coord_t v_act, v_fp, v_sw, v_bp;
logic                   neg;

// Derived edges
vid_bridge_pkg::coord_t h_sst, h_send, h_total;
vid_bridge_pkg::coord_t v_sst, v_send, v_total;

vid_bridge_pkg::coord_t hcount;
vid_bridge_pkg::coord_t vcount;
logic                   line_end;
logic                   frame_end;

////////////////////////////////////////////////////////////////////////
// Format lookup
////////////////////////////////////////////////////////////////////////
always_comb begin
	case (mode_q)
		vid_bridge_pkg::MODE_VGA: begin
			h_act = `VB_VGA_HPIXELS;  h_fp = `VB_VGA_HFNPRCH;
			h_sw  = `VB_VGA_HSYNCPW;  h_bp = `VB_VGA_HBKPRCH;
			v_act = `VB_VGA_VLINES;   v_fp = `VB_VGA_VFNPRCH;
			v_sw  = `VB_VGA_VSYNCPW;  v_bp = `VB_VGA_VBKPRCH;
			neg   = `VB_VGA_NEG;
		end
		vid_bridge_pkg::MODE_SVGA: begin
			h_act = `VB_SVGA_HPIXELS; h_fp = `VB_SVGA_HFNPRCH;
			h_sw  = `VB_SVGA_HSYNCPW; h_bp = `VB_SVGA_HBKPRCH;
			v_act = `VB_SVGA_VLINES;  v_fp = `VB_SVGA_VFNPRCH;
			v_sw  = `VB_SVGA_VSYNCPW; v_bp = `VB_SVGA_VBKPRCH;
			neg   = `VB_SVGA_NEG;
		end
		vid_bridge_pkg::MODE_XGA: begin
			h_act = `VB_XGA_HPIXELS;  h_fp = `VB_XGA_HFNPRCH;
			h_sw  = `VB_XGA_HSYNCPW;  h_bp = `VB_XGA_HBKPRCH;
			v_act = `VB_XGA_VLINES;   v_fp = `VB_XGA_VFNPRCH;
			v_sw  = `VB_XGA_VSYNCPW;  v_bp = `VB_XGA_VBKPRCH;
			neg   = `VB_XGA_NEG;
		end
		default: begin // 720p and unlisted codes
			h_act = `VB_720P_HPIXELS; h_fp = `VB_720P_HFNPRCH;
			h_sw  = `VB_720P_HSYNCPW; h_bp = `VB_720P_HBKPRCH;
			v_act = `VB_720P_VLINES;  v_fp = `VB_720P_VFNPRCH;
			v_sw  = `VB_720P_VSYNCPW; v_bp = `VB_720P_VBKPRCH;
			neg   = `VB_720P_NEG;
		end
	endcase
end

assign h_sst   = h_act + h_fp;   // Sync starts after front porch
assign h_send  = h_sst + h_sw;
assign h_total = h_send + h_bp;  // Full line incl. blanking
assign v_sst   = v_act + v_fp;
assign v_send  = v_sst + v_sw;
assign v_total = v_send + v_bp;

assign line_end  = (hcount == h_total - 11'd1);
assign frame_end = line_end && (vcount == v_total - 11'd1);

////////////////////////////////////////////////////////////////////////
// Counters and format latch
////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
	if (serdes_rst) begin
		mode_q <= vid_bridge_pkg::MODE_VGA;
		hcount <= '0;
		vcount <= '0;
	end else begin
		if (frame_end)
			mode_q <= mode; // New format from next frame
		if (line_end) begin
			hcount <= '0;
			vcount <= frame_end ? '0 : vcount + 11'd1;
		end else begin
			hcount <= hcount + 11'd1;
		end
	end
end

// Blank and raw sync decode
assign rst_bus.hcount    = hcount;
assign rst_bus.vcount    = vcount;
assign rst_bus.hblnk     = (hcount >= h_act);
assign rst_bus.vblnk     = (vcount >= v_act);
assign rst_bus.hsync_raw = (hcount >= h_sst) && (hcount < h_send);
assign rst_bus.vsync_raw = (vcount >= v_sst) && (vcount < v_send);
assign rst_bus.sync_neg  = neg;

// Format only moves at the wrap, so counters stay inside the new frame
a_h_in_line: assert property (
	@(posedge clk50m_bufg) disable iff (serdes_rst)
	(hcount < h_total) && (vcount < v_total)
) else $error("raster_timing_gen: counter past frame total");

endmodule

/* rtl/video_out_stage.sv */
`timescale 1ns/1ps

`include "vid_bridge_macros.svh"

module video_out_stage (
	input  logic                   clk50m_bufg,
	input  logic                   serdes_rst,
	raster_if.sink                 rst_bus,
	input  logic                   avail,    // Buffer head valid
	input  vid_bridge_pkg::pixel_t head,
	output logic                   pop,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   de,
	output vid_bridge_pkg::pixel_t rgb,
	output logic                   underrun  // Empty buffer in active video
);

logic                   active;
vid_bridge_pkg::pixel_t px_sel;

// Stage 1 regs
logic                   hsync_q;
logic                   vsync_q;
logic                   de_q;
logic                   urun_q;
vid_bridge_pkg::pixel_t rgb_q;

assign active = !rst_bus.hblnk && !rst_bus.vblnk;
assign pop    = active && avail;                     // One word per active pixel
assign px_sel = pop ? head : `VB_FILL_PIXEL;         // Black when nothing to show

////////////////////////////////////////////////////////////////////////
// Two register stages, sync/DE/pixel stay aligned
////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
	if (serdes_rst) begin
		hsync_q  <= 1'b1; // Idle level for VGA, active low
		vsync_q  <= 1'b1;
		de_q     <= 1'b0;
		urun_q   <= 1'b0;
		hsync    <= 1'b1;
		vsync    <= 1'b1;
		de       <= 1'b0;
		underrun <= 1'b0;
	end else begin
		hsync_q  <= rst_bus.hsync_raw ^ rst_bus.sync_neg; // Polarity fix
		vsync_q  <= rst_bus.vsync_raw ^ rst_bus.sync_neg;
		de_q     <= active;
		urun_q   <= active && !avail;
		hsync    <= hsync_q;
		vsync    <= vsync_q;
		de       <= de_q;
		underrun <= urun_q;
	end
end

// Pixel payload pipe
always_ff @(posedge clk50m_bufg) begin
	rgb_q <= px_sel;
	rgb   <= rgb_q;
end

endmodule

/* rtl/vid_bridge_top.sv */
`timescale 1ns/1ps

module vid_bridge_top (
	input  logic                      clk50m_bufg,
	input  logic                      serdes_rst,
	input  vid_bridge_pkg::vid_mode_e mode,          // Format request
	input  logic                      px_valid,      // Producer beat
	input  vid_bridge_pkg::pixel_t    px_data,
	output logic                      credit_return, // Credit back to producer
	output logic                      hsync,
	output logic                      vsync,
	output logic                      de,
	output vid_bridge_pkg::pixel_t    rgb,
	output logic                      underrun
);

// Buffer to output stage
logic                   pop;
logic                   avail;
vid_bridge_pkg::pixel_t head;

raster_if rst_bus ();

////////////////////////////////////////////////////////////////////////
// Receive buffer, raster timing, output stage
////////////////////////////////////////////////////////////////////////
pixel_rx_buffer u_rx_buf (
	.clk50m_bufg   (clk50m_bufg),
	.serdes_rst    (serdes_rst),
	.px_valid      (px_valid),
	.px_data       (px_data),
	.pop           (pop),
	.head          (head),
	.avail         (avail),
	.credit_return (credit_return)
);

raster_timing_gen u_timing (
	.clk50m_bufg (clk50m_bufg),
	.serdes_rst  (serdes_rst),
	.mode        (mode),
	.rst_bus     (rst_bus.gen)
);

video_out_stage u_out (
	.clk50m_bufg (clk50m_bufg),
	.serdes_rst  (serdes_rst),
	.rst_bus     (rst_bus.sink),
	.avail       (avail),
	.head        (head),
	.pop         (pop),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de),
	.rgb         (rgb),
	.underrun    (underrun)
);

endmodule

/* tests/tb_vid_bridge.sv */
`timescale 1ns/1ps

`include "vid_bridge_macros.svh"

module tb_vid_bridge;

// Horizontal timing of one format, counted from the first active pixel
typedef struct packed {
	logic [10:0] total; // Line length in clocks
	logic [10:0] act;   // Active width
	logic [10:0] sst;   // Sync start
	logic [10:0] sw;    // Sync width
	logic        neg;   // Active low sync
} line_ref_t;

logic                      clk50m_bufg;
logic                      serdes_rst;
vid_bridge_pkg::vid_mode_e mode;
logic                      px_valid;
vid_bridge_pkg::pixel_t    px_data;
logic                      credit_return;
logic                      hsync;
logic                      vsync;
logic                      de;
vid_bridge_pkg::pixel_t    rgb;
logic                      underrun;

int                     errors;
int                     checks;
int                     urun_cnt;   // Black pixels in active video
int                     credits;    // Held by the producer
int                     spent;      // Beats sent
int                     returned;   // Credit pulses seen
bit                     send_en;    // Producer may send
bit                     flow_chk;   // Underrun is an error while set
bit                     seeded;     // Producer RNG already seeded
vid_bridge_pkg::pixel_t px_count;   // Next value to send
vid_bridge_pkg::pixel_t exp_px;     // Next value expected on rgb

vid_bridge_top u_dut (
	.clk50m_bufg   (clk50m_bufg),
	.serdes_rst    (serdes_rst),
	.mode          (mode),
	.px_valid      (px_valid),
	.px_data       (px_data),
	.credit_return (credit_return),
	.hsync         (hsync),
	.vsync         (vsync),
	.de            (de),
	.rgb           (rgb),
	.underrun      (underrun)
);

always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

function automatic line_ref_t ref_line(input vid_bridge_pkg::vid_mode_e m);
	line_ref_t r;
	case (m)
		vid_bridge_pkg::MODE_VGA: begin
			r.act = `VB_VGA_HPIXELS;
			r.sst = `VB_VGA_HPIXELS + `VB_VGA_HFNPRCH;
			r.sw  = `VB_VGA_HSYNCPW;
			r.total = r.sst + r.sw + `VB_VGA_HBKPRCH;
			r.neg = `VB_VGA_NEG;
		end
		vid_bridge_pkg::MODE_SVGA: begin
			r.act = `VB_SVGA_HPIXELS;
			r.sst = `VB_SVGA_HPIXELS + `VB_SVGA_HFNPRCH;
			r.sw  = `VB_SVGA_HSYNCPW;
			r.total = r.sst + r.sw + `VB_SVGA_HBKPRCH;
			r.neg = `VB_SVGA_NEG;
		end
		vid_bridge_pkg::MODE_XGA: begin
			r.act = `VB_XGA_HPIXELS;
			r.sst = `VB_XGA_HPIXELS + `VB_XGA_HFNPRCH;
			r.sw  = `VB_XGA_HSYNCPW;
			r.total = r.sst + r.sw + `VB_XGA_HBKPRCH;
			r.neg = `VB_XGA_NEG;
		end
		default: begin // 720p fallback
			r.act = `VB_720P_HPIXELS;
			r.sst = `VB_720P_HPIXELS + `VB_720P_HFNPRCH;
			r.sw  = `VB_720P_HSYNCPW;
			r.total = r.sst + r.sw + `VB_720P_HBKPRCH;
			r.neg = `VB_720P_NEG;
		end
	endcase
	return r;
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
	end
endtask

task automatic finish_run;
	$display("Summary: %0d errors, %0d checks, %0d underrun pixels", errors, checks, urun_cnt);
	if (errors == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
endtask

task automatic abort_on_timeout(input string what);
	$display("Timeout at %0t ns while waiting for %s", $time, what);
	errors++;
	finish_run;
endtask

// Output picked for a wait, 0 de, 1 hsync, else vsync
function automatic logic probe(input int sel);
	case (sel)
		0:       return de;
		1:       return hsync;
		default: return vsync;
	endcase
endfunction

task automatic wait_level(input int sel, input logic level, input int limit, input string what);
	int n;
	n = 0;
	while (probe(sel) !== level) begin
		@(negedge clk50m_bufg);
		n++;
		if (n > limit)
			abort_on_timeout(what);
	end
endtask

// Starts on a de rise, returns on the next one
task automatic measure_line(input line_ref_t r, input string tag);
	int   n;
	int   t_fall;
	int   t_sst;
	int   t_send;
	bit   done;
	logic prev_de;
	logic prev_hs;
	n = 0;
	t_fall = -1;
	t_sst = -1;
	t_send = -1;
	done = 1'b0;
	prev_de = de;
	prev_hs = hsync;
	check_eq(hsync, r.neg, {tag, " hsync idle level in active video"});
	check_eq(vsync, r.neg, {tag, " vsync idle level in active video"});
	while (!done) begin
		@(negedge clk50m_bufg);
		n++;
		if (prev_de && !de)
			t_fall = n;
		if (prev_hs == r.neg && hsync != r.neg)
			t_sst = n;              // Sync goes active
		if (prev_hs != r.neg && hsync == r.neg)
			t_send = n;
		done = !prev_de && de;
		prev_de = de;
		prev_hs = hsync;
		if (!done && n >= 4096)
			abort_on_timeout({tag, " next de rise"});
	end
	check_eq(t_fall, r.act, {tag, " de high run"});
	check_eq(t_sst - t_fall, r.sst - r.act, {tag, " hsync start after de fall"});
	check_eq(t_send - t_sst, r.sw, {tag, " hsync width"});
	check_eq(n, r.total, {tag, " de rise to rise"});
endtask

////////////////////////////////////////////////////////////////////////
// Producer, one beat per held credit
////////////////////////////////////////////////////////////////////////
always @(posedge clk50m_bufg) begin
	if (serdes_rst) begin
		px_valid <= 1'b0;
		credits = `VB_FIFO_DEPTH;
		if (!seeded) begin
			void'($urandom(32'h23ee_1eea)); // Fixed seed for the idle pattern
			seeded = 1'b1;
		end
	end else begin
		if (credit_return) begin
			credits++;
			returned++;
		end
		check_eq(returned <= spent, 1'b1, "credits returned exceed credits spent");
		// Idles only outside active video, so the buffer keeps up
		if (send_en && credits > 0 && (de || ($urandom % 4) != 0)) begin
			px_valid <= 1'b1;
			px_data  <= px_count;
			px_count++;
			credits--;
			spent++;
		end else begin
			px_valid <= 1'b0;
		end
	end
end

////////////////////////////////////////////////////////////////////////
// Pixel compare, sampled mid-cycle
////////////////////////////////////////////////////////////////////////
always @(negedge clk50m_bufg) begin
	if (!serdes_rst) begin
		if (de && underrun) begin
			urun_cnt++;
			check_eq(rgb, `VB_FILL_PIXEL, "black pixel on underrun");
		end else if (de) begin
			check_eq(rgb, exp_px, "pixel sequence");
			exp_px++;
		end else begin
			check_eq(underrun, 1'b0, "underrun outside active video");
		end
		if (flow_chk)
			check_eq(underrun, 1'b0, "underrun while producer follows credits");
	end
end

initial begin : main_seq
	int                     urun_before;
	vid_bridge_pkg::pixel_t px_before;
	clk50m_bufg = 1'b0;
	serdes_rst  = 1'b1;
	mode        = vid_bridge_pkg::MODE_VGA;
	px_valid    = 1'b0;
	px_data     = '0;
	errors      = 0;
	checks      = 0;
	urun_cnt    = 0;
	spent       = 0;
	returned    = 0;
	send_en     = 1'b1;
	flow_chk    = 1'b0;
	px_count    = 24'd1;
	exp_px      = 24'd1;

	repeat (5) @(posedge clk50m_bufg);
	serdes_rst <= 1'b0;

	// Idle outputs before first active pixel
	@(negedge clk50m_bufg);
	check_eq(de, 1'b0, "de after reset");
	check_eq(underrun, 1'b0, "underrun after reset");
	check_eq(credit_return, 1'b0, "credit_return after reset");
	check_eq(hsync, 1'b1, "hsync idle after reset");
	check_eq(vsync, 1'b1, "vsync idle after reset");

	// Line 0 starts on an empty buffer
	wait_level(0, 1'b1, 100, "first de");
	wait_level(0, 1'b0, 4096, "end of first line");
	flow_chk = 1'b1;

	// VGA line timing and polarity
	wait_level(0, 1'b1, 4096, "second VGA line");
	repeat (40) measure_line(ref_line(vid_bridge_pkg::MODE_VGA), "VGA");

	// SVGA applies from the next frame wrap
	@(posedge clk50m_bufg);
	mode <= vid_bridge_pkg::MODE_SVGA;
	@(negedge clk50m_bufg);
	wait_level(2, ~vsync, 1000000, "VGA vsync edge");
	check_eq(vsync, 1'b0, "VGA vsync active low");
	wait_level(0, 1'b1, 100000, "first SVGA line");
	repeat (20) measure_line(ref_line(vid_bridge_pkg::MODE_SVGA), "SVGA");

	////////////////////////////////////////////////////////////////////
	// Starve one line, then resume
	////////////////////////////////////////////////////////////////////
	flow_chk = 1'b0;
	urun_before = urun_cnt;
	send_en = 1'b0;
	wait_level(0, 1'b0, 4096, "end of starved line");
	wait_level(0, 1'b1, 4096, "line after starved line");
	check_eq(urun_cnt > urun_before, 1'b1, "underrun seen on starved line");
	px_before = exp_px;
	send_en = 1'b1;
	wait_level(0, 1'b0, 4096, "end of resumed line");
	check_eq(exp_px > px_before, 1'b1, "pixels flow again after resume");
	flow_chk = 1'b1;
	wait_level(0, 1'b1, 4096, "line after resume");
	wait_level(0, 1'b0, 4096, "end of last line");
	finish_run;
end

endmodule

/* vid_bridge.f */
+incdir+rtl
rtl/vid_bridge_pkg.sv
rtl/raster_if.sv
rtl/pixel_rx_buffer.sv
rtl/raster_timing_gen.sv
rtl/video_out_stage.sv
rtl/vid_bridge_top.sv
tests/tb_vid_bridge.sv

/* Bender.yml */
package:
  name: vid_bridge

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vid_bridge_pkg.sv
      - rtl/raster_if.sv
      - rtl/pixel_rx_buffer.sv
      - rtl/raster_timing_gen.sv
      - rtl/video_out_stage.sv
      - rtl/vid_bridge_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_vid_bridge.sv
